// File: verilog/vlsu_pkg.sv
//////////////////////////////
// Vector LSU widths and limits, element types
// and the address generator FSM states
//////////////////////////////

package vlsu_pkg;

  // Bus and element widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int SEL_WIDTH  = DATA_WIDTH / 8;

  // Vector length limits
  localparam int MAX_VL    = 16;
  localparam int VL_WIDTH  = $clog2(MAX_VL + 1);
  localparam int IDX_WIDTH = $clog2(MAX_VL);

  // Entries in the load data queue
  localparam int LOAD_QUEUE_DEPTH = 2;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [SEL_WIDTH-1:0]  sel_t;
  typedef logic [VL_WIDTH-1:0]   vl_t;
  typedef logic [IDX_WIDTH-1:0]  idx_t;

  // Idle, issuing addresses, waiting for the unit to finish
  typedef enum logic [1:0] {
    AG_IDLE,
    AG_GEN,
    AG_WAIT
  } addrgen_state_e;

endpackage

// File: verilog/vlsu_addrgen.sv
//////////////////////////////
// Command acceptance, legality check and
// element address sequence
//////////////////////////////
`timescale 1ns/1ps

module vlsu_addrgen (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Command
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  logic            cmd_store_i,
  input  vlsu_pkg::addr_t cmd_base_i,
  input  vlsu_pkg::addr_t cmd_stride_i,
  input  vlsu_pkg::vl_t   cmd_vl_i,
  output logic            cmd_error_o,
  // Completion from the units
  input  logic            load_complete_i,
  input  logic            store_complete_i,
  // Address stream
  output logic            addr_valid_o,
  input  logic            addr_ready_i,
  output vlsu_pkg::addr_t addr_o,
  output logic            addr_store_o,
  // Unit start
  output logic            ld_start_o,
  output logic            st_start_o,
  output vlsu_pkg::vl_t   vl_o
);
  import vlsu_pkg::*;

  addrgen_state_e state_q;
  addr_t          stride_q;
  vl_t            remain_q;
  logic           cmd_fire;
  logic           cmd_legal;
  logic           addr_fire;
  logic           done;

  // Ready stays low during the error pulse cycle
  assign cmd_ready_o = (state_q == AG_IDLE) && !cmd_error_o;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;
  assign cmd_legal   = (cmd_base_i[1:0] == 2'b00) && (cmd_stride_i[1:0] == 2'b00) &&
                       (cmd_vl_i != '0);

  assign addr_valid_o = (state_q == AG_GEN);
  assign addr_fire    = addr_valid_o && addr_ready_i;
  assign done         = addr_store_o ? store_complete_i : load_complete_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= AG_IDLE;
      remain_q     <= '0;
      addr_store_o <= 1'b0;
      cmd_error_o  <= 1'b0;
      ld_start_o   <= 1'b0;
      st_start_o   <= 1'b0;
    end else begin
      cmd_error_o <= cmd_fire && !cmd_legal;
      ld_start_o  <= cmd_fire && cmd_legal && !cmd_store_i;
      st_start_o  <= cmd_fire && cmd_legal && cmd_store_i;
      case (state_q)
        AG_IDLE: begin
          if (cmd_fire && cmd_legal) begin
            state_q      <= AG_GEN;
            remain_q     <= cmd_vl_i;
            addr_store_o <= cmd_store_i;
          end
        end
        AG_GEN: begin
          if (addr_fire) begin
            remain_q <= remain_q - vl_t'(1);
            // Last element handed over
            if (remain_q == vl_t'(1)) begin
              state_q <= AG_WAIT;
            end
          end
        end
        AG_WAIT: begin
          if (done) begin
            state_q <= AG_IDLE;
          end
        end
        default: state_q <= AG_IDLE;
      endcase
    end
  end

  // Address walks by the stride after each handshake
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      addr_o   <= cmd_base_i;
      stride_q <= cmd_stride_i;
      vl_o     <= cmd_vl_i;
    end else if (addr_fire) begin
      addr_o <= addr_o + stride_q;
    end
  end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o));

  a_no_idle_complete: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q == AG_IDLE |-> !(load_complete_i || store_complete_i));

endmodule

// File: verilog/vlsu_wb_master.sv
//////////////////////////////
// Wishbone classic master, one access
// per element address
//////////////////////////////
`timescale 1ns/1ps

module vlsu_wb_master (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Address stream
  input  logic            addr_valid_i,
  output logic            addr_ready_o,
  input  vlsu_pkg::addr_t addr_i,
  input  logic            addr_store_i,
  // Store data
  input  logic            wdata_valid_i,
  output logic            wdata_ready_o,
  input  vlsu_pkg::data_t wdata_i,
  output logic            wr_ack_o,
  // Read data to the load queue
  input  logic            q_full_i,
  output logic            rd_push_o,
  output vlsu_pkg::data_t rd_data_o,
  // Wishbone
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic            wb_we_o,
  output vlsu_pkg::addr_t wb_adr_o,
  output vlsu_pkg::data_t wb_dat_o,
  output vlsu_pkg::sel_t  wb_sel_o,
  input  vlsu_pkg::data_t wb_dat_i,
  input  logic            wb_ack_i
);
  import vlsu_pkg::*;

  logic  cyc_q;
  logic  stb_q;
  logic  we_q;
  addr_t adr_q;
  data_t dat_q;
  logic  start;
  logic  ack;

  // Loads need queue space, stores need an operand
  assign addr_ready_o  = !cyc_q && (addr_store_i ? wdata_valid_i : !q_full_i);
  assign wdata_ready_o = !cyc_q && addr_valid_i && addr_store_i;
  assign start         = addr_valid_i && addr_ready_o;
  assign ack           = cyc_q && wb_ack_i;

  assign rd_push_o = ack && !we_q;
  assign rd_data_o = wb_dat_i;
  assign wr_ack_o  = ack && we_q;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = stb_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = '1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
      we_q  <= 1'b0;
    end else if (start) begin
      cyc_q <= 1'b1;
      stb_q <= 1'b1;
      we_q  <= addr_store_i;
    end else if (ack) begin
      // Bus idles for a cycle after each access
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= addr_i;
      dat_q <= wdata_i;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_cyc_o);

endmodule

// File: verilog/vlsu_load_queue.sv
//////////////////////////////
// Load data queue, small FIFO
//////////////////////////////
`timescale 1ns/1ps

module vlsu_load_queue (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  vlsu_pkg::data_t data_i,
  output logic            full_o,
  output logic            valid_o,
  output vlsu_pkg::data_t data_o,
  input  logic            pop_i
);
  import vlsu_pkg::*;

  typedef logic [$clog2(LOAD_QUEUE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(LOAD_QUEUE_DEPTH+1)-1:0] cnt_t;

  data_t mem_q [LOAD_QUEUE_DEPTH];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;

  assign full_o  = (count_q == cnt_t'(LOAD_QUEUE_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o);

endmodule

// File: verilog/vlsu_load_unit.sv
//////////////////////////////
// Load result tagging and completion
//////////////////////////////
`timescale 1ns/1ps

module vlsu_load_unit (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  vlsu_pkg::vl_t   vl_i,
  // Queue head
  input  logic            q_valid_i,
  input  vlsu_pkg::data_t q_data_i,
  output logic            q_pop_o,
  // Result stream
  output logic            ld_result_valid_o,
  input  logic            ld_result_ready_i,
  output vlsu_pkg::idx_t  ld_result_idx_o,
  output vlsu_pkg::data_t ld_result_data_o,
  output logic            load_complete_o
);
  import vlsu_pkg::*;

  logic active_q;
  vl_t  vl_q;
  idx_t idx_q;
  logic last;

  assign ld_result_valid_o = active_q && q_valid_i;
  assign ld_result_idx_o   = idx_q;
  assign ld_result_data_o  = q_data_i;
  assign q_pop_o           = ld_result_valid_o && ld_result_ready_i;

  // Element vl-1 ends the load
  assign last = (vl_t'(idx_q) == vl_q - vl_t'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q        <= 1'b0;
      idx_q           <= '0;
      load_complete_o <= 1'b0;
    end else begin
      load_complete_o <= q_pop_o && last;
      if (start_i) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (q_pop_o) begin
        if (last) begin
          active_q <= 1'b0;
        end else begin
          idx_q <= idx_q + idx_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      vl_q <= vl_i;
    end
  end

endmodule

// File: verilog/vlsu_store_unit.sv
//////////////////////////////
// Store operand forwarding and write
// acknowledge counting
//////////////////////////////
`timescale 1ns/1ps

module vlsu_store_unit (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  vlsu_pkg::vl_t   vl_i,
  // Operand stream
  input  logic            st_operand_valid_i,
  output logic            st_operand_ready_o,
  input  vlsu_pkg::data_t st_operand_i,
  // Write data to the bus master
  output logic            wdata_valid_o,
  output vlsu_pkg::data_t wdata_o,
  input  logic            wdata_ready_i,
  input  logic            wr_ack_i,
  output logic            store_complete_o
);
  import vlsu_pkg::*;

  logic active_q;
  vl_t  vl_q;
  vl_t  ack_cnt_q;
  logic last;

  // Operands pass only while a store runs
  assign wdata_valid_o      = active_q && st_operand_valid_i;
  assign wdata_o            = st_operand_i;
  assign st_operand_ready_o = active_q && wdata_ready_i;

  assign last = (ack_cnt_q == vl_q - vl_t'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q         <= 1'b0;
      ack_cnt_q        <= '0;
      store_complete_o <= 1'b0;
    end else begin
      store_complete_o <= active_q && wr_ack_i && last;
      if (start_i) begin
        active_q  <= 1'b1;
        ack_cnt_q <= '0;
      end else if (active_q && wr_ack_i) begin
        if (last) begin
          active_q <= 1'b0;
        end else begin
          ack_cnt_q <= ack_cnt_q + vl_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      vl_q <= vl_i;
    end
  end

endmodule

// File: verilog/vlsu_top.sv
//////////////////////////////
// Vector load/store unit top level
//////////////////////////////
`timescale 1ns/1ps

module vlsu_top (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Command
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  logic            cmd_store_i,
  input  vlsu_pkg::addr_t cmd_base_i,
  input  vlsu_pkg::addr_t cmd_stride_i,
  input  vlsu_pkg::vl_t   cmd_vl_i,
  output logic            cmd_error_o,
  // Store operands
  input  logic            st_operand_valid_i,
  output logic            st_operand_ready_o,
  input  vlsu_pkg::data_t st_operand_i,
  // Load results
  output logic            ld_result_valid_o,
  input  logic            ld_result_ready_i,
  output vlsu_pkg::idx_t  ld_result_idx_o,
  output vlsu_pkg::data_t ld_result_data_o,
  // Completion
  output logic            load_complete_o,
  output logic            store_complete_o,
  // Wishbone
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic            wb_we_o,
  output vlsu_pkg::addr_t wb_adr_o,
  output vlsu_pkg::data_t wb_dat_o,
  output vlsu_pkg::sel_t  wb_sel_o,
  input  vlsu_pkg::data_t wb_dat_i,
  input  logic            wb_ack_i
);
  import vlsu_pkg::*;

  logic  addr_valid, addr_ready, addr_store;
  addr_t addr;
  logic  ld_start, st_start;
  vl_t   vl;
  logic  wdata_valid, wdata_ready, wr_ack;
  data_t wdata;
  logic  rd_push, q_full, q_valid, q_pop;
  data_t rd_data, q_data;

  //////////////////////////////
  // Address generation
  //////////////////////////////

  vlsu_addrgen i_addrgen (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_ready_o      (cmd_ready_o),
    .cmd_store_i      (cmd_store_i),
    .cmd_base_i       (cmd_base_i),
    .cmd_stride_i     (cmd_stride_i),
    .cmd_vl_i         (cmd_vl_i),
    .cmd_error_o      (cmd_error_o),
    .load_complete_i  (load_complete_o),
    .store_complete_i (store_complete_o),
    .addr_valid_o     (addr_valid),
    .addr_ready_i     (addr_ready),
    .addr_o           (addr),
    .addr_store_o     (addr_store),
    .ld_start_o       (ld_start),
    .st_start_o       (st_start),
    .vl_o             (vl)
  );

  //////////////////////////////
  // Bus master
  //////////////////////////////

  vlsu_wb_master i_wb_master (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .addr_valid_i  (addr_valid),
    .addr_ready_o  (addr_ready),
    .addr_i        (addr),
    .addr_store_i  (addr_store),
    .wdata_valid_i (wdata_valid),
    .wdata_ready_o (wdata_ready),
    .wdata_i       (wdata),
    .wr_ack_o      (wr_ack),
    .q_full_i      (q_full),
    .rd_push_o     (rd_push),
    .rd_data_o     (rd_data),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_o      (wb_dat_o),
    .wb_sel_o      (wb_sel_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  //////////////////////////////
  // Load and store paths
  //////////////////////////////

  vlsu_load_queue i_load_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rd_push),
    .data_i  (rd_data),
    .full_o  (q_full),
    .valid_o (q_valid),
    .data_o  (q_data),
    .pop_i   (q_pop)
  );

  vlsu_load_unit i_load_unit (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .start_i           (ld_start),
    .vl_i              (vl),
    .q_valid_i         (q_valid),
    .q_data_i          (q_data),
    .q_pop_o           (q_pop),
    .ld_result_valid_o (ld_result_valid_o),
    .ld_result_ready_i (ld_result_ready_i),
    .ld_result_idx_o   (ld_result_idx_o),
    .ld_result_data_o  (ld_result_data_o),
    .load_complete_o   (load_complete_o)
  );

  vlsu_store_unit i_store_unit (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .start_i            (st_start),
    .vl_i               (vl),
    .st_operand_valid_i (st_operand_valid_i),
    .st_operand_ready_o (st_operand_ready_o),
    .st_operand_i       (st_operand_i),
    .wdata_valid_o      (wdata_valid),
    .wdata_o            (wdata),
    .wdata_ready_i      (wdata_ready),
    .wr_ack_i           (wr_ack),
    .store_complete_o   (store_complete_o)
  );

endmodule

// File: verification/vlsu_wb_mem.sv
//////////////////////////////
// Wishbone classic memory model
// with random wait states
//////////////////////////////
`timescale 1ns/1ps

module vlsu_wb_mem (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  vlsu_pkg::addr_t wb_adr_i,
  input  vlsu_pkg::data_t wb_dat_i,
  input  vlsu_pkg::sel_t  wb_sel_i,
  output vlsu_pkg::data_t wb_dat_o,
  output logic            wb_ack_o
);
  import vlsu_pkg::*;

  localparam int WORDS = 256;

  data_t      mem [WORDS];
  logic       busy_q;
  logic [1:0] wait_q;
  logic [7:0] word;

  // Byte address bits 9:2 pick one of 256 words
  assign word = wb_adr_i[9:2];

  initial begin
    for (int w = 0; w < WORDS; w++) begin
      mem[w] <= 32'hA5A5_0000 ^ data_t'(w);
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      wait_q   <= '0;
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy_q) begin
          // 0 to 3 extra wait cycles per access
          busy_q <= 1'b1;
          wait_q <= 2'($urandom % 4);
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q   <= 1'b0;
          wb_ack_o <= 1'b1;
          if (wb_we_i) begin
            for (int b = 0; b < SEL_WIDTH; b++) begin
              if (wb_sel_i[b]) begin
                mem[word][8*b +: 8] <= wb_dat_i[8*b +: 8];
              end
            end
          end else begin
            wb_dat_o <= mem[word];
          end
        end
      end
    end
  end

endmodule

// File: verification/vlsu_tb.sv
//////////////////////////////
// Vector LSU testbench, command table
// checked against a shadow memory
//////////////////////////////
`timescale 1ns/1ps

module vlsu_tb;
  import vlsu_pkg::*;

  localparam int NUM_ROWS = 10;

  logic  clk_i;
  logic  rst_n_i;
  logic  cmd_valid_i;
  logic  cmd_ready_o;
  logic  cmd_store_i;
  addr_t cmd_base_i;
  addr_t cmd_stride_i;
  vl_t   cmd_vl_i;
  logic  cmd_error_o;
  logic  st_operand_valid_i;
  logic  st_operand_ready_o;
  data_t st_operand_i;
  logic  ld_result_valid_o;
  logic  ld_result_ready_i;
  idx_t  ld_result_idx_o;
  data_t ld_result_data_o;
  logic  load_complete_o;
  logic  store_complete_o;
  logic  wb_cyc_o;
  logic  wb_stb_o;
  logic  wb_we_o;
  addr_t wb_adr_o;
  data_t wb_dat_o;
  sel_t  wb_sel_o;
  data_t wb_dat_i;
  logic  wb_ack_i;

  // Command table
  logic  row_store  [NUM_ROWS];
  addr_t row_base   [NUM_ROWS];
  addr_t row_stride [NUM_ROWS];
  vl_t   row_vl     [NUM_ROWS];
  logic  row_err    [NUM_ROWS];

  data_t shadow [256];

  // Cycle count and per-row tallies
  int   cycles;
  int   cycle_limit;
  int   cyc_rises;
  int   bus_acks;
  int   ld_done;
  int   st_done;
  logic cyc_prev;

  vlsu_top u_dut (.*);

  vlsu_wb_mem u_mem (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_dat_i (wb_dat_o),
    .wb_sel_i (wb_sel_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic data_ok(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic idx_ok(input string what, input idx_t got, input idx_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Index mismatch");
    end
  endtask

  task automatic flag_ok(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic sel_ok(input string what, input sel_t got, input sel_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Byte select mismatch");
    end
  endtask

  task automatic count_ok(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t: %0d %s seen, expected %0d", $time, got, what, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Count mismatch");
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // One clock, sampled at the falling edge
  task automatic step();
    @(negedge clk_i);
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation timed out");
    end
    if (wb_cyc_o && !cyc_prev) begin
      cyc_rises++;
    end
    cyc_prev = wb_cyc_o;
    if (wb_cyc_o && wb_ack_i) begin
      bus_acks++;
    end
    // Strobe only inside a bus cycle, all byte lanes selected
    if (wb_cyc_o) begin
      flag_ok("wb_stb_o", wb_stb_o, 1'b1);
      sel_ok("wb_sel_o", wb_sel_o, '1);
    end else begin
      flag_ok("wb_stb_o", wb_stb_o, 1'b0);
    end
    if (load_complete_o) begin
      ld_done++;
    end
    if (store_complete_o) begin
      st_done++;
    end
  endtask

  task automatic add_row(input int r, input logic st, input addr_t base,
                         input addr_t stride, input vl_t vl, input logic err);
    row_store[r]  = st;
    row_base[r]   = base;
    row_stride[r] = stride;
    row_vl[r]     = vl;
    row_err[r]    = err;
  endtask

  task automatic build_table();
    for (int w = 0; w < 256; w++) begin
      shadow[w] = 32'hA5A5_0000 ^ data_t'(w);
    end
    add_row(0, 1'b0, 32'h040, 32'd4,  5'd8,  1'b0);
    add_row(1, 1'b0, 32'h100, 32'd12, 5'd16, 1'b0);
    add_row(2, 1'b0, 32'h042, 32'd4,  5'd4,  1'b1);
    add_row(3, 1'b1, 32'h200, 32'd4,  5'd6,  1'b0);
    add_row(4, 1'b0, 32'h200, 32'd4,  5'd6,  1'b0);
    add_row(5, 1'b0, 32'h040, 32'd6,  5'd4,  1'b1);
    add_row(6, 1'b1, 32'h300, 32'd8,  5'd5,  1'b0);
    // Overlaps the strided store above
    add_row(7, 1'b0, 32'h2F8, 32'd4,  5'd16, 1'b0);
    add_row(8, 1'b1, 32'h040, 32'd4,  5'd0,  1'b1);
    add_row(9, 1'b0, 32'h3C0, 32'd4,  5'd16, 1'b0);
  endtask

  function automatic data_t store_pattern(input int r, input int i);
    return {8'h5A, 8'(r), 16'(i) * 16'h1111};
  endfunction

  function automatic addr_t elem_addr(input int r, input int i);
    return row_base[r] + addr_t'(i) * row_stride[r];
  endfunction

  task automatic load_row(input int r);
    int    count;
    logic  rdy;
    addr_t a;
    count = 0;
    while (count < int'(row_vl[r])) begin
      rdy = ($urandom % 4) != 0;
      ld_result_ready_i = rdy;
      if (ld_result_valid_o && rdy) begin
        a = elem_addr(r, count);
        idx_ok("ld_result_idx_o", ld_result_idx_o, idx_t'(count));
        data_ok("ld_result_data_o", ld_result_data_o, shadow[a[9:2]]);
        count++;
      end
      step();
    end
    ld_result_ready_i = 1'b0;
    flag_ok("load_complete_o", load_complete_o, 1'b1);
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b0);
    step();
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b1);
    flag_ok("ld_result_valid_o", ld_result_valid_o, 1'b0);
    count_ok("load completions", ld_done, 1);
    count_ok("store completions", st_done, 0);
    count_ok("bus cycles", cyc_rises, int'(row_vl[r]));
  endtask

  task automatic store_row(input int r);
    int    count;
    addr_t a;
    count = 0;
    while (count < int'(row_vl[r])) begin
      st_operand_valid_i = 1'b1;
      st_operand_i       = store_pattern(r, count);
      if (st_operand_ready_o) begin
        a = elem_addr(r, count);
        shadow[a[9:2]] = store_pattern(r, count);
        count++;
      end
      step();
    end
    st_operand_valid_i = 1'b0;
    while (bus_acks < int'(row_vl[r])) begin
      step();
    end
    // Completion follows the last write acknowledge
    flag_ok("store_complete_o", store_complete_o, 1'b0);
    step();
    flag_ok("store_complete_o", store_complete_o, 1'b1);
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b0);
    step();
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b1);
    flag_ok("st_operand_ready_o", st_operand_ready_o, 1'b0);
    count_ok("store completions", st_done, 1);
    count_ok("load completions", ld_done, 0);
    count_ok("bus cycles", cyc_rises, int'(row_vl[r]));
  endtask

  task automatic reject_row();
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b0);
    step();
    flag_ok("cmd_error_o", cmd_error_o, 1'b0);
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b1);
    repeat (4) step();
    count_ok("bus cycles", cyc_rises, 0);
    count_ok("load completions", ld_done, 0);
    count_ok("store completions", st_done, 0);
  endtask

  task automatic apply_row(input int r);
    while (!cmd_ready_o) begin
      step();
    end
    cmd_valid_i  = 1'b1;
    cmd_store_i  = row_store[r];
    cmd_base_i   = row_base[r];
    cmd_stride_i = row_stride[r];
    cmd_vl_i     = row_vl[r];
    cyc_rises    = 0;
    bus_acks     = 0;
    ld_done      = 0;
    st_done      = 0;
    // Accepted on this edge
    step();
    cmd_valid_i = 1'b0;
    flag_ok("cmd_error_o", cmd_error_o, row_err[r]);
    if (row_err[r]) begin
      reject_row();
    end else if (row_store[r]) begin
      store_row(r);
    end else begin
      load_row(r);
    end
    $display("Row %0d finished at %0t", r, $time);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n_i            = 1'b0;
    cmd_valid_i        = 1'b0;
    cmd_store_i        = 1'b0;
    cmd_base_i         = '0;
    cmd_stride_i       = '0;
    cmd_vl_i           = '0;
    st_operand_valid_i = 1'b0;
    st_operand_i       = '0;
    ld_result_ready_i  = 1'b0;
    cycles             = 0;
    cycle_limit        = 0;
    cyc_rises          = 0;
    bus_acks           = 0;
    ld_done            = 0;
    st_done            = 0;
    cyc_prev           = 1'b0;
    void'($urandom(61));
    build_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += int'(row_vl[r]) * 8 + 20;
    end

    repeat (2) step();
    rst_n_i = 1'b1;
    flag_ok("cmd_ready_o", cmd_ready_o, 1'b1);
    flag_ok("cmd_error_o", cmd_error_o, 1'b0);
    flag_ok("wb_cyc_o", wb_cyc_o, 1'b0);
    flag_ok("wb_stb_o", wb_stb_o, 1'b0);
    flag_ok("ld_result_valid_o", ld_result_valid_o, 1'b0);
    flag_ok("st_operand_ready_o", st_operand_ready_o, 1'b0);
    flag_ok("load_complete_o", load_complete_o, 1'b0);
    flag_ok("store_complete_o", store_complete_o, 1'b0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: filelist.f
verilog/vlsu_pkg.sv
verilog/vlsu_addrgen.sv
verilog/vlsu_wb_master.sv
verilog/vlsu_load_queue.sv
verilog/vlsu_load_unit.sv
verilog/vlsu_store_unit.sv
verilog/vlsu_top.sv
verification/vlsu_wb_mem.sv
verification/vlsu_tb.sv

// File: Makefile
# Verilator build and run for the vector LSU testbench

VERILATOR ?= verilator
TOP       ?= vlsu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
